// File: fma_pipe.f
+incdir+design
design/fma_data_pkg.sv
design/fma_flow_pkg.sv
design/prefix_adder.sv
design/csa_tree.sv
design/product_resolve.sv
design/operand_delay.sv
design/accum_add.sv
design/result_buffer.sv
design/fma_pipe.sv
verif/tb_fma_pipe.sv

// File: run_sim.sh
#!/bin/sh
# builds the fma_pipe testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_fma_pipe \
   -f fma_pipe.f \
   -o sim_fma_pipe
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/sim_fma_pipe
status=$?
if [ $status -ne 0 ]; then
   echo "simulation ended with status $status"
   exit $status
fi

exit 0

// File: verif/tb_fma_pipe.sv
`timescale 1ns/10ps

`include "fma_defs.svh"

module tb_fma_pipe import fma_data_pkg::*, fma_flow_pkg::*; ();

   localparam int DEPTH = `FMA_BUF_DEPTH;
   localparam int MIN_LAT = 4 + `FMA_DELAY_STAGES;
   localparam int N_RANDOM = 40;
   localparam int N_OPS = 4 + N_RANDOM + DEPTH;
   localparam credit_cnt_t FULL_CREDITS = credit_cnt_t'(DEPTH);
   localparam op_t OP_ONES = '1;
   localparam acc_t ACC_ONES = '1;

   logic clk;
   logic rst;
   logic in_valid;
   op_t  in_a;
   op_t  in_b;
   acc_t in_c;
   logic res_credit;
   logic in_credit;
   logic res_valid;
   acc_t res_data;

   // reference model updated on the rising edge
   acc_t        exp_q [$];
   acc_t        exp_head;
   int          exp_count;
   credit_cnt_t up_held;
   credit_cnt_t dn_held;
   logic        granted;
   logic        seen_in;
   logic        seen_out;
   int          edge_cnt;
   int          first_in_edge;
   int          credit_pulses;

   logic give_credits;
   logic withheld;

   fma_pipe i_fma_pipe (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_a       (in_a),
      .in_b       (in_b),
      .in_c       (in_c),
      .res_credit (res_credit),
      .in_credit  (in_credit),
      .res_valid  (res_valid),
      .res_data   (res_data)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "run aborted");
   endtask

   task automatic print_mismatch(input string name, input acc_t expected, input acc_t actual);
      $display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
      abort_run();
   endtask

   task automatic fail_with_reason(input string what);
      $display("error at %0t ns: %s", $time, what);
      abort_run();
   endtask

   always @(posedge clk or negedge rst) begin
      if (!rst) begin
         exp_q.delete();
         exp_head = '0;
         exp_count = 0;
         up_held <= FULL_CREDITS;
         dn_held <= '0;
         granted <= 1'b0;
         seen_in <= 1'b0;
         seen_out <= 1'b0;
         edge_cnt <= 0;
         first_in_edge <= 0;
         credit_pulses <= 0;
      end else begin
         if (res_valid) begin
            void'(exp_q.pop_front());
            seen_out <= 1'b1;
         end
         if (in_valid) begin
            // a times b plus c wrapped to 64 bits
            exp_q.push_back(acc_t'(in_a) * acc_t'(in_b) + in_c);
            if (!seen_in) begin
               first_in_edge <= edge_cnt + 1;
            end
            seen_in <= 1'b1;
         end
         exp_count = exp_q.size();
         exp_head = (exp_count != 0) ? exp_q[0] : '0;
         up_held <= up_held - credit_cnt_t'(in_valid) + credit_cnt_t'(in_credit);
         dn_held <= dn_held + credit_cnt_t'(res_credit) - credit_cnt_t'(res_valid);
         if (res_credit) begin
            granted <= 1'b1;
         end
         if (in_credit) begin
            credit_pulses <= credit_pulses + 1;
         end
         edge_cnt <= edge_cnt + 1;
      end
   end

   // checked mid-cycle where outputs and model state are settled
   a_quiet: assert property (@(negedge clk) disable iff (!rst)
      !granted |-> !res_valid && !in_credit)
      else fail_with_reason("output activity before any downstream credit");
   a_has_op: assert property (@(negedge clk) disable iff (!rst)
      res_valid |-> exp_count != 0)
      else fail_with_reason("result with no operation outstanding");
   a_res_data: assert property (@(negedge clk) disable iff (!rst)
      res_valid |-> res_data == exp_head)
      else print_mismatch("res_data", exp_head, res_data);
   a_dn_credit: assert property (@(negedge clk) disable iff (!rst)
      res_valid |-> dn_held != '0)
      else fail_with_reason("res_valid without a downstream credit");
   a_credit_pair: assert property (@(negedge clk) disable iff (!rst)
      in_credit == res_valid)
      else print_mismatch("in_credit", acc_t'(res_valid), acc_t'(in_credit));
   a_withheld: assert property (@(negedge clk) disable iff (!rst)
      withheld |-> !in_credit)
      else fail_with_reason("in_credit pulsed while downstream credits were withheld");
   // res_valid is sampled at the edge after this check
   a_min_lat: assert property (@(negedge clk) disable iff (!rst)
      res_valid && !seen_out |-> edge_cnt + 1 - first_in_edge >= MIN_LAT)
      else print_mismatch("first latency", acc_t'(MIN_LAT), acc_t'(edge_cnt + 1 - first_in_edge));

   task automatic idle_cycle();
      // one grant per result still owed
      res_credit = give_credits && (int'(dn_held) < exp_count);
      @(posedge clk);
      #2;
      res_credit = 1'b0;
   endtask

   task automatic issue_op(input op_t a, input op_t b, input acc_t c);
      while (up_held == '0) begin
         idle_cycle();
      end
      in_valid = 1'b1;
      in_a = a;
      in_b = b;
      in_c = c;
      idle_cycle();
      in_valid = 1'b0;
   endtask

   task automatic drain_results();
      while (exp_count != 0) begin
         idle_cycle();
      end
   endtask

   initial begin
      int pulses_before;
      void'($urandom(32'h90bf65d0));
      rst = 1'b0;
      in_valid = 1'b0;
      in_a = '0;
      in_b = '0;
      in_c = '0;
      res_credit = 1'b0;
      give_credits = 1'b0;
      withheld = 1'b0;
      repeat (5) @(posedge clk);
      #2;
      rst = 1'b1;
      repeat (4) idle_cycle();

      // free flow with corner operands first
      give_credits = 1'b1;
      issue_op('0, '0, '0);
      issue_op(OP_ONES, OP_ONES, ACC_ONES);
      issue_op(OP_ONES, OP_ONES, '0);
      issue_op('0, OP_ONES, {$urandom(), $urandom()});
      for (int i = 0; i < N_RANDOM; i++) begin
         issue_op($urandom(), $urandom(), {$urandom(), $urandom()});
      end
      drain_results();
      assert (up_held == FULL_CREDITS)
         else print_mismatch("upstream credits", acc_t'(FULL_CREDITS), acc_t'(up_held));

      // back-pressure lets the buffer fill and upstream run dry
      give_credits = 1'b0;
      withheld = 1'b1;
      for (int i = 0; i < DEPTH; i++) begin
         issue_op($urandom(), OP_ONES, {$urandom(), $urandom()});
      end
      repeat (MIN_LAT + 2) idle_cycle();
      assert (up_held == '0)
         else print_mismatch("upstream credits", '0, acc_t'(up_held));
      pulses_before = credit_pulses;
      withheld = 1'b0;
      give_credits = 1'b1;
      drain_results();
      repeat (4) idle_cycle();
      assert (credit_pulses - pulses_before == DEPTH)
         else print_mismatch("in_credit pulses", acc_t'(DEPTH),
                             acc_t'(credit_pulses - pulses_before));
      $display("Simulation passed");
      $finish;
   end

   // 200 cycles plus 40 per operation
   initial begin
      repeat (200 + 40 * N_OPS) @(posedge clk);
      fail_with_reason("watchdog expired before the tests finished");
   end

endmodule

// File: design/fma_pipe.sv
`timescale 1ns/10ps

`include "fma_defs.svh"

module fma_pipe import fma_data_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic in_valid,
   input  op_t  in_a,
   input  op_t  in_b,
   input  acc_t in_c,
   input  logic res_credit,
   output logic in_credit,
   output logic res_valid,
   output acc_t res_data
);

   logic row_valid;
   acc_t sum_row;
   acc_t carry_row;
   acc_t row_c;
   logic prod_valid;
   acc_t prod;
   acc_t prod_c;
   logic dly_valid;
   acc_t dly_prod;
   logic addend_valid;
   acc_t dly_addend;
   logic sum_valid;
   acc_t sum;

   csa_tree i_csa_tree (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_a      (in_a),
      .in_b      (in_b),
      .in_c      (in_c),
      .row_valid (row_valid),
      .sum_row   (sum_row),
      .carry_row (carry_row),
      .row_c     (row_c)
   );

   product_resolve i_product_resolve (
      .clk        (clk),
      .rst        (rst),
      .row_valid  (row_valid),
      .sum_row    (sum_row),
      .carry_row  (carry_row),
      .row_c      (row_c),
      .prod_valid (prod_valid),
      .prod       (prod),
      .prod_c     (prod_c)
   );

   // product and addend ride matching delay lines
   operand_delay #(
      .payload_t (acc_t),
      .DEPTH     (`FMA_DELAY_STAGES)
   ) i_prod_delay (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (prod_valid),
      .in_data   (prod),
      .out_valid (dly_valid),
      .out_data  (dly_prod)
   );

   operand_delay #(
      .payload_t (acc_t),
      .DEPTH     (`FMA_DELAY_STAGES)
   ) i_addend_delay (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (prod_valid),
      .in_data   (prod_c),
      .out_valid (addend_valid),
      .out_data  (dly_addend)
   );

   accum_add i_accum_add (
      .clk        (clk),
      .rst        (rst),
      .prod_valid (dly_valid),
      .prod       (dly_prod),
      .addend     (dly_addend),
      .sum_valid  (sum_valid),
      .sum        (sum)
   );

   result_buffer i_result_buffer (
      .clk        (clk),
      .rst        (rst),
      .wr_valid   (sum_valid),
      .wr_data    (sum),
      .res_credit (res_credit),
      .res_valid  (res_valid),
      .res_data   (res_data),
      .in_credit  (in_credit)
   );

   // accum_add takes one valid, so both delay lines must stay in step
   a_delay_aligned: assert property (@(posedge clk) disable iff (!rst)
      dly_valid == addend_valid);

endmodule

// File: design/result_buffer.sv
`timescale 1ns/10ps

`include "fma_defs.svh"

module result_buffer import fma_data_pkg::*, fma_flow_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic wr_valid,
   input  acc_t wr_data,
   input  logic res_credit,
   output logic res_valid,
   output acc_t res_data,
   output logic in_credit
);

   localparam int DEPTH = `FMA_BUF_DEPTH;
   localparam credit_cnt_t FULL = credit_cnt_t'(DEPTH);

   acc_t        mem [DEPTH];
   buf_ptr_t    wr_ptr;
   buf_ptr_t    rd_ptr;
   credit_cnt_t fill;
   credit_cnt_t dn_credits;
   logic        pop;

   function automatic buf_ptr_t next_ptr(input buf_ptr_t ptr);
      if (ptr == buf_ptr_t'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // one result per cycle while something is held and downstream has room
   assign pop = (fill != '0) && (dn_credits != '0);
   assign res_valid = pop;
   assign res_data = mem[rd_ptr];
   // the freed entry goes straight back to upstream as a credit
   assign in_credit = pop;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill <= '0;
         dn_credits <= '0;
      end else begin
         if (wr_valid) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         fill <= fill + credit_cnt_t'(wr_valid) - credit_cnt_t'(pop);
         dn_credits <= dn_credits + credit_cnt_t'(res_credit) - credit_cnt_t'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (wr_valid) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // upstream credit budget must keep the fifo from overflowing
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
      wr_valid |-> fill != FULL);

   // downstream never holds more than DEPTH unspent grants
   a_credit_range: assert property (@(posedge clk) disable iff (!rst)
      res_credit && !res_valid |-> dn_credits != FULL);

endmodule

// File: design/accum_add.sv
`timescale 1ns/10ps

module accum_add import fma_data_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic prod_valid,
   input  acc_t prod,
   input  acc_t addend,
   output logic sum_valid,
   output acc_t sum
);

   acc_t sum_comb;

   // final add, result wraps modulo 2**64
   prefix_adder i_prefix_adder (
      .op_x (prod),
      .op_y (addend),
      .sum  (sum_comb)
   );

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         sum_valid <= 1'b0;
      end else begin
         sum_valid <= prod_valid;
      end
   end

   always_ff @(posedge clk) begin
      sum <= sum_comb;
   end

endmodule

// File: design/operand_delay.sv
`timescale 1ns/10ps

module operand_delay #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 1
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     out_valid,
   output payload_t out_data
);

   logic [DEPTH-1:0] vld;
   payload_t         pipe [DEPTH];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         vld <= '0;
      end else begin
         vld[0] <= in_valid;
         for (int i = 1; i < DEPTH; i++) begin
            vld[i] <= vld[i-1];
         end
      end
   end

   // payload just follows its valid bit down the line
   always_ff @(posedge clk) begin
      pipe[0] <= in_data;
      for (int i = 1; i < DEPTH; i++) begin
         pipe[i] <= pipe[i-1];
      end
   end

   assign out_valid = vld[DEPTH-1];
   assign out_data = pipe[DEPTH-1];

endmodule

// File: design/product_resolve.sv
`timescale 1ns/10ps

module product_resolve import fma_data_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic row_valid,
   input  acc_t sum_row,
   input  acc_t carry_row,
   input  acc_t row_c,
   output logic prod_valid,
   output acc_t prod,
   output acc_t prod_c
);

   acc_t prod_comb;

   // collapse the carry-save pair into the full product
   prefix_adder i_prefix_adder (
      .op_x (sum_row),
      .op_y (carry_row),
      .sum  (prod_comb)
   );

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         prod_valid <= 1'b0;
      end else begin
         prod_valid <= row_valid;
      end
   end

   always_ff @(posedge clk) begin
      prod <= prod_comb;
      prod_c <= row_c;
   end

endmodule

// File: design/csa_tree.sv
`timescale 1ns/10ps

`include "fma_defs.svh"

module csa_tree import fma_data_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic in_valid,
   input  op_t  in_a,
   input  op_t  in_b,
   input  acc_t in_c,
   output logic row_valid,
   output acc_t sum_row,
   output acc_t carry_row,
   output acc_t row_c
);

   // rows left after lv layers of 3:2 compressors
   function automatic int rows_at(input int lv);
      int n;
      n = `FMA_OP_W;
      for (int i = 0; i < lv; i++) begin
         n = (n / 3) * 2 + n % 3;
      end
      return n;
   endfunction

   function automatic int level_count();
      int n;
      int lv;
      n = `FMA_OP_W;
      lv = 0;
      while (n > 2) begin
         n = (n / 3) * 2 + n % 3;
         lv++;
      end
      return lv;
   endfunction

   localparam int LEVELS = level_count();

   acc_t tree [0:LEVELS][0:`FMA_OP_W-1];

   // partial product i is b gated by a[i], shifted into place
   for (genvar i = 0; i < `FMA_OP_W; i++) begin : g_pp
      assign tree[0][i] = acc_t'(in_b & {`FMA_OP_W{in_a[i]}}) << i;
   end

   for (genvar lv = 0; lv < LEVELS; lv++) begin : g_level
      localparam int N = rows_at(lv);
      localparam int G = N / 3;
      for (genvar g = 0; g < G; g++) begin : g_csa
         assign tree[lv+1][2*g] = tree[lv][3*g] ^ tree[lv][3*g+1] ^ tree[lv][3*g+2];
         assign tree[lv+1][2*g+1] = ((tree[lv][3*g] & tree[lv][3*g+1]) |
                                     (tree[lv][3*g] & tree[lv][3*g+2]) |
                                     (tree[lv][3*g+1] & tree[lv][3*g+2])) << 1;
      end
      // leftover rows skip this layer
      for (genvar r = 0; r < N % 3; r++) begin : g_pass
         assign tree[lv+1][2*G+r] = tree[lv][3*G+r];
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         row_valid <= 1'b0;
      end else begin
         row_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      sum_row <= tree[LEVELS][0];
      carry_row <= tree[LEVELS][1];
      row_c <= in_c;
   end

endmodule

// File: design/prefix_adder.sv
`timescale 1ns/10ps

module prefix_adder import fma_data_pkg::*; (
   input  acc_t op_x,
   input  acc_t op_y,
   output acc_t sum
);

   localparam int W = $bits(acc_t);
   localparam int LEVELS = $clog2(W);

   // gen[lv][i] is the group generate of bits i down to i - 2**lv + 1
   acc_t gen [0:LEVELS];
   acc_t prop [0:LEVELS-1];

   assign gen[0] = op_x & op_y;
   assign prop[0] = op_x ^ op_y;

   for (genvar lv = 0; lv < LEVELS; lv++) begin : g_level
      localparam int DIST = 1 << lv;
      // low bits have no partner at this distance and keep their value
      assign gen[lv+1] = gen[lv] | (prop[lv] & (gen[lv] << DIST));
      if (lv < LEVELS - 1) begin : g_prop
         assign prop[lv+1] = prop[lv] & ((prop[lv] << DIST) | acc_t'({DIST{1'b1}}));
      end
   end

   // carry into bit i is the prefix generate of bit i-1, carry out dropped
   assign sum = prop[0] ^ (gen[LEVELS] << 1);

endmodule

// File: design/fma_flow_pkg.sv
`include "fma_defs.svh"

package fma_flow_pkg;

   localparam int CNT_W = $clog2(`FMA_BUF_DEPTH + 1);
   localparam int PTR_W = (`FMA_BUF_DEPTH > 1) ? $clog2(`FMA_BUF_DEPTH) : 1;

   // holds 0 up to the full buffer depth
   typedef logic [CNT_W-1:0] credit_cnt_t;

   // index into the result fifo
   typedef logic [PTR_W-1:0] buf_ptr_t;

endpackage

// File: design/fma_data_pkg.sv
`include "fma_defs.svh"

package fma_data_pkg;

   // one multiplier operand
   typedef logic [`FMA_OP_W-1:0] op_t;

   // addend, partial product rows, product and result
   typedef logic [`FMA_ACC_W-1:0] acc_t;

endpackage

// File: design/fma_defs.svh
`ifndef FMA_DEFS_SVH
`define FMA_DEFS_SVH

// multiplier operand width
`define FMA_OP_W 32

// addend, product and result width, twice the operand width
`define FMA_ACC_W 64

// cycles the product waits between resolve and accumulate
// any value of 1 or more
`define FMA_DELAY_STAGES 4

// result fifo entries, also the upstream credit budget
`define FMA_BUF_DEPTH 4

`endif
